/* src.f */
common/demux_pkg.sv
logic/clock_gate.sv
fifo/order_fifo.sv
demux/addr_decoder.sv
demux/resp_merger.sv
demux/req_demux_top.sv
verification/req_demux_sva.sv
verification/tb_req_demux.sv

/* Makefile */
# Verilator simulation of the request demultiplexer

VERILATOR ?= verilator
TOP       ?= tb_req_demux
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: help build test clean

help:
	@echo "make test   build and run the simulation, pass if $(LOG) holds the pass line"
	@echo "make clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "make help   show this list"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "^TEST OK$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/tb_req_demux.sv */
// ----------------------------------------------------------
// Request demultiplexer testbench
// ----------------------------------------------------------

`timescale 1ns/100ps

module tb_req_demux;

   localparam int CLK_HALF  = 50;
   localparam int DRIVE_DLY = 10;
   // About 180 requests, well under 16 cycles each
   localparam int MAX_CYCLES = 4000;

   logic                                    clk = 1'b0;
   logic                                    rst_n;
   logic                                    clear_i;
   logic                                    test_mode_i;
   logic                                    req_valid_i;
   logic                                    req_ready_o;
   logic [demux_pkg::ADDR_WIDTH-1:0]        req_addr_i;
   demux_pkg::req_op_e                      req_op_i;
   logic [demux_pkg::DATA_WIDTH-1:0]        req_wdata_i;
   logic                                    resp_valid_o;
   logic                                    resp_ready_i = 1'b0;
   logic [demux_pkg::DATA_WIDTH-1:0]        resp_rdata_o;
   logic                                    resp_err_o;
   logic [demux_pkg::NUM_SLAVES-1:0]        slv_req_valid_o;
   wire  [demux_pkg::NUM_SLAVES-1:0]        slv_req_ready_i;
   logic [demux_pkg::ADDR_WIDTH-1:0]        slv_req_addr_o;
   demux_pkg::req_op_e                      slv_req_op_o;
   logic [demux_pkg::DATA_WIDTH-1:0]        slv_req_wdata_o;
   wire  [demux_pkg::NUM_SLAVES-1:0]        slv_resp_valid_i;
   logic [demux_pkg::NUM_SLAVES-1:0]        slv_resp_ready_o;
   wire  [demux_pkg::NUM_SLAVES-1:0][demux_pkg::DATA_WIDTH-1:0] slv_resp_rdata_i;

   integer seed = 32'h6437_219a;
   int     cycle_cnt = 0;
   int     n_acc = 0;
   int     n_resp = 0;
   int     n_tests = 0;
   int     fails_seen = 0;
   logic   resp_hold = 1'b0;
   logic   ready_rnd = 1'b0;

   req_demux_top i_dut (.*);

   always #CLK_HALF clk = ~clk;

   // Run limit
   always @(posedge clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES)
      begin
         $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("TEST FAILED");
         $finish;
      end
   end

   // Handshake seen mid cycle completes at the next edge
   always @(negedge clk)
   begin
      if (rst_n && resp_valid_o && resp_ready_i)
      begin
         n_resp <= n_resp + 1;
      end
   end

   // Master response ready, random stalls in the ordering test
   always @(posedge clk)
   begin
      #DRIVE_DLY;
      resp_ready_i = ready_rnd ? (($random(seed) & 3) != 0) : 1'b1;
   end

   // Slave models, in order with 0 to 7 cycles of delay
   genvar k;
   generate
      for (k = 0; k < demux_pkg::NUM_SLAVES; k++)
      begin : g_slave
         logic [31:0] pend_q [$];
         logic [31:0] addr_in;
         logic [2:0]  delay = 3'd0;
         logic        rvalid = 1'b0;
         logic [31:0] rdata = '0;
         logic        qready = 1'b0;
         logic        req_fire;
         logic        resp_fire;
         logic        flush;

         assign slv_req_ready_i[k]  = qready;
         assign slv_resp_valid_i[k] = rvalid;
         assign slv_resp_rdata_i[k] = rdata;

         always
         begin
            @(negedge clk);
            req_fire  = slv_req_valid_o[k] & qready;
            resp_fire = rvalid & slv_resp_ready_o[k];
            flush     = clear_i | !rst_n;
            addr_in   = slv_req_addr_o;
            @(posedge clk);
            #DRIVE_DLY;
            if (flush)
            begin
               pend_q.delete();
            end
            else
            begin
               if (resp_fire)
               begin
                  void'(pend_q.pop_front());
                  delay = $random(seed);
               end
               else if (delay != 3'd0 && pend_q.size() != 0)
               begin
                  delay = delay - 3'd1;
               end
               if (req_fire)
               begin
                  pend_q.push_back(addr_in);
               end
            end
            rvalid = (pend_q.size() != 0) && (delay == 3'd0) && !resp_hold;
            rdata  = (pend_q.size() != 0) ? (pend_q[0] ^ 32'hA5A5_0000) : '0;
            qready = !ready_rnd || (($random(seed) & 1) != 0);
         end
      end
   endgenerate

   task automatic next_cycle();
      @(posedge clk);
      #DRIVE_DLY;
   endtask

   // Holds valid until ready is seen, then counts the transfer
   task automatic wait_accept();
      logic taken;
      taken = 1'b0;
      while (!taken)
      begin
         @(negedge clk);
         taken = req_ready_o;
         next_cycle();
      end
      req_valid_i = 1'b0;
      n_acc++;
   endtask

   task automatic offer_req(input logic [31:0] addr);
      req_valid_i = 1'b1;
      req_addr_i  = addr;
      req_op_i    = (($random(seed) & 1) != 0) ? demux_pkg::OP_WRITE : demux_pkg::OP_READ;
      req_wdata_i = $random(seed);
   endtask

   task automatic send_req(input logic [31:0] addr);
      offer_req(addr);
      wait_accept();
   endtask

   task automatic drain();
      while (n_resp != n_acc)
      begin
         next_cycle();
      end
   endtask

   task automatic report_test(input string name);
      int fails;
      fails      = i_dut.i_sva.fail_cnt - fails_seen;
      fails_seen = i_dut.i_sva.fail_cnt;
      n_tests++;
      $display("%-13s finished at %0t with %0d assertion failures", name, $time, fails);
   endtask

   function automatic logic [31:0] mapped_addr();
      return $random(seed) & 32'h0000_3FFC;
   endfunction

   // Anywhere from the top of the map upward
   function automatic logic [31:0] unmapped_addr();
      return 32'h0000_4000 + ($random(seed) & 32'h0FFF_FFFC);
   endfunction

   initial
   begin
      int i;
      rst_n       = 1'b0;
      clear_i     = 1'b0;
      test_mode_i = 1'b0;
      req_valid_i = 1'b0;
      req_addr_i  = '0;
      req_op_i    = demux_pkg::OP_READ;
      req_wdata_i = '0;
      repeat (16) @(posedge clk);
      #DRIVE_DLY;
      rst_n = 1'b1;

      repeat (4) next_cycle();
      report_test("reset");

      for (i = 0; i < 20; i++) send_req(mapped_addr());
      drain();
      report_test("routing");

      // Random slave and master stalls
      ready_rnd = 1'b1;
      for (i = 0; i < 100; i++) send_req(mapped_addr());
      drain();
      ready_rnd = 1'b0;
      report_test("ordering");

      // Roughly one in four unmapped, storage clock forced on
      test_mode_i = 1'b1;
      for (i = 0; i < 40; i++)
      begin
         send_req((($random(seed) & 3) == 0) ? unmapped_addr() : mapped_addr());
      end
      drain();
      test_mode_i = 1'b0;
      report_test("decode_error");

      // Ninth request waits for a free FIFO entry
      resp_hold = 1'b1;
      for (i = 0; i < 8; i++) send_req(mapped_addr());
      offer_req(mapped_addr());
      repeat (6) next_cycle();
      resp_hold = 1'b0;
      wait_accept();
      drain();
      report_test("backpressure");

      // Flush eight held requests
      resp_hold = 1'b1;
      for (i = 0; i < 8; i++) send_req(mapped_addr());
      repeat (4) next_cycle();
      clear_i = 1'b1;
      next_cycle();
      clear_i   = 1'b0;
      n_acc     = n_resp;
      resp_hold = 1'b0;
      for (i = 0; i < 4; i++) send_req(mapped_addr());
      drain();
      report_test("clear");

      $display("tests run %0d, assertion failures %0d", n_tests, i_dut.i_sva.fail_cnt);
      if (i_dut.i_sva.fail_cnt == 0)
      begin
         $display("TEST OK");
      end
      else
      begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* verification/req_demux_sva.sv */
// ----------------------------------------------------------
// Request demultiplexer checks
// ----------------------------------------------------------

`timescale 1ns/100ps

module req_demux_sva
(
   input logic                               clk,
   input logic                               rst_n,
   input logic                               clear_i,
   input logic                               req_valid_i,
   input logic                               req_ready_o,
   input logic [demux_pkg::ADDR_WIDTH-1:0]   req_addr_i,
   input demux_pkg::req_op_e                 req_op_i,
   input logic [demux_pkg::DATA_WIDTH-1:0]   req_wdata_i,
   input logic                               resp_valid_o,
   input logic                               resp_ready_i,
   input logic [demux_pkg::DATA_WIDTH-1:0]   resp_rdata_o,
   input logic                               resp_err_o,
   input logic [demux_pkg::NUM_SLAVES-1:0]   slv_req_valid_o,
   input logic [demux_pkg::ADDR_WIDTH-1:0]   slv_req_addr_o,
   input demux_pkg::req_op_e                 slv_req_op_o,
   input logic [demux_pkg::DATA_WIDTH-1:0]   slv_req_wdata_o,
   input logic [demux_pkg::NUM_SLAVES-1:0]   slv_resp_ready_o
);

   int                                unsigned fail_cnt = 0;
   logic                              seen_req;
   logic                              accept;
   logic                              resp_fire;
   logic                              req_err;
   logic [demux_pkg::NUM_SLAVES-1:0]  sel_onehot;
   logic [demux_pkg::NUM_SLAVES-1:0]  head_slave;
   logic [3:0]                        wr_ptr;
   logic [3:0]                        rd_ptr;
   logic [3:0]                        outstanding;

   // Expected responses in acceptance order
   logic [demux_pkg::DATA_WIDTH-1:0]  exp_rdata [16];
   logic                              exp_err [16];
   // One-hot slave per entry, zero for a decode error
   logic [demux_pkg::NUM_SLAVES-1:0]  exp_slave [16];

   assign accept      = req_valid_i & req_ready_o;
   assign resp_fire   = resp_valid_o & resp_ready_i;
   assign req_err     = (req_addr_i >= 32'h0000_4000);
   assign sel_onehot  = {{(demux_pkg::NUM_SLAVES - 1){1'b0}}, 1'b1} << req_addr_i[13:12];
   assign outstanding = wr_ptr - rd_ptr;
   // Slave owed the oldest outstanding response
   assign head_slave  = (outstanding != 4'd0) ? exp_slave[rd_ptr] : '0;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         seen_req <= 1'b0;
         wr_ptr   <= '0;
         rd_ptr   <= '0;
      end
      else
      begin
         seen_req <= seen_req | req_valid_i;
         // Clear throws away every outstanding entry
         wr_ptr   <= clear_i ? 4'd0 : wr_ptr + {3'd0, accept};
         rd_ptr   <= clear_i ? 4'd0 : rd_ptr + {3'd0, resp_fire};
      end
   end

   // Slaves return address XOR A5A5_0000, decode errors return zero
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         exp_rdata[wr_ptr] <= req_err ? '0 : (req_addr_i ^ 32'hA5A5_0000);
         exp_err[wr_ptr]   <= req_err;
         exp_slave[wr_ptr] <= req_err ? '0 : sel_onehot;
      end
   end

   idle_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
      !seen_req |-> req_ready_o && (slv_req_valid_o == '0) && !resp_valid_o)
      else begin $error("mismatch at %0t: DUT not idle after reset", $time); fail_cnt++; end

   route_valid: assert property (@(posedge clk) disable iff (!rst_n)
      accept && !req_err |=> slv_req_valid_o == $past(sel_onehot))
      else begin $error("mismatch at %0t: wrong slave valid", $time); fail_cnt++; end

   route_payload: assert property (@(posedge clk) disable iff (!rst_n)
      accept && !req_err |=> (slv_req_addr_o == $past(req_addr_i))
         && (slv_req_op_o == $past(req_op_i)) && (slv_req_wdata_o == $past(req_wdata_i)))
      else begin $error("mismatch at %0t: slave payload differs", $time); fail_cnt++; end

   err_no_slave: assert property (@(posedge clk) disable iff (!rst_n)
      accept && req_err |=> slv_req_valid_o == '0)
      else begin $error("mismatch at %0t: decode error reached a slave", $time); fail_cnt++; end

   resp_expected: assert property (@(posedge clk) disable iff (!rst_n)
      resp_valid_o |-> outstanding != 4'd0)
      else begin $error("response offered with no request outstanding"); fail_cnt++; end

   resp_in_order: assert property (@(posedge clk) disable iff (!rst_n)
      resp_fire |-> (resp_rdata_o == exp_rdata[rd_ptr]) && (resp_err_o == exp_err[rd_ptr]))
      else begin $error("mismatch at %0t: response out of order", $time); fail_cnt++; end

   // Only the head slave may see the master ready
   resp_ready_to_head: assert property (@(posedge clk) disable iff (!rst_n)
      slv_resp_ready_o == (resp_ready_i ? head_slave : '0))
      else begin $error("mismatch at %0t: response ready at wrong slave", $time); fail_cnt++; end

   full_stalls: assert property (@(posedge clk) disable iff (!rst_n)
      outstanding == 4'd8 |-> !req_ready_o)
      else begin $error("request accepted beyond eight outstanding"); fail_cnt++; end

   clear_empties: assert property (@(posedge clk) disable iff (!rst_n)
      clear_i |=> req_ready_o && !resp_valid_o)
      else begin $error("mismatch at %0t: FIFO not empty after clear", $time); fail_cnt++; end

endmodule

bind req_demux_top req_demux_sva i_sva (.*);

/* demux/req_demux_top.sv */
// ----------------------------------------------------------
// Request demultiplexer top
// ----------------------------------------------------------

`timescale 1ns/100ps

module req_demux_top
(
   input  logic                                                    clk,
   input  logic                                                    rst_n,
   input  logic                                                    clear_i,
   input  logic                                                    test_mode_i,

   // Master request
   input  logic                                                    req_valid_i,
   output logic                                                    req_ready_o,
   input  logic [demux_pkg::ADDR_WIDTH-1:0]                        req_addr_i,
   input  demux_pkg::req_op_e                                      req_op_i,
   input  logic [demux_pkg::DATA_WIDTH-1:0]                        req_wdata_i,

   // Master response
   output logic                                                    resp_valid_o,
   input  logic                                                    resp_ready_i,
   output logic [demux_pkg::DATA_WIDTH-1:0]                        resp_rdata_o,
   output logic                                                    resp_err_o,

   // Slave requests
   output logic [demux_pkg::NUM_SLAVES-1:0]                        slv_req_valid_o,
   input  logic [demux_pkg::NUM_SLAVES-1:0]                        slv_req_ready_i,
   output logic [demux_pkg::ADDR_WIDTH-1:0]                        slv_req_addr_o,
   output demux_pkg::req_op_e                                      slv_req_op_o,
   output logic [demux_pkg::DATA_WIDTH-1:0]                        slv_req_wdata_o,

   // Slave responses
   input  logic [demux_pkg::NUM_SLAVES-1:0]                        slv_resp_valid_i,
   output logic [demux_pkg::NUM_SLAVES-1:0]                        slv_resp_ready_o,
   input  logic [demux_pkg::NUM_SLAVES-1:0][demux_pkg::DATA_WIDTH-1:0] slv_resp_rdata_i
);

   // Decoder to FIFO
   logic                             push_valid;
   logic                             push_ready;
   logic [demux_pkg::DEST_WIDTH-1:0] push_dest;

   // FIFO to merger
   logic                             pop_valid;
   logic                             pop_ready;
   logic [demux_pkg::DEST_WIDTH-1:0] pop_dest;

   addr_decoder i_addr_decoder
   (
      .clk             (clk),
      .rst_n           (rst_n),
      .req_valid_i     (req_valid_i),
      .req_ready_o     (req_ready_o),
      .req_addr_i      (req_addr_i),
      .req_op_i        (req_op_i),
      .req_wdata_i     (req_wdata_i),
      .push_valid_o    (push_valid),
      .push_dest_o     (push_dest),
      .push_ready_i    (push_ready),
      .slv_req_valid_o (slv_req_valid_o),
      .slv_req_ready_i (slv_req_ready_i),
      .slv_req_addr_o  (slv_req_addr_o),
      .slv_req_op_o    (slv_req_op_o),
      .slv_req_wdata_o (slv_req_wdata_o)
   );

   order_fifo i_order_fifo
   (
      .clk          (clk),
      .rst_n        (rst_n),
      .clear_i      (clear_i),
      .test_mode_i  (test_mode_i),
      .push_valid_i (push_valid),
      .push_dest_i  (push_dest),
      .push_ready_o (push_ready),
      .pop_valid_o  (pop_valid),
      .pop_dest_o   (pop_dest),
      .pop_ready_i  (pop_ready)
   );

   resp_merger i_resp_merger
   (
      .pop_valid_i      (pop_valid),
      .pop_dest_i       (pop_dest),
      .pop_ready_o      (pop_ready),
      .slv_resp_valid_i (slv_resp_valid_i),
      .slv_resp_ready_o (slv_resp_ready_o),
      .slv_resp_rdata_i (slv_resp_rdata_i),
      .resp_valid_o     (resp_valid_o),
      .resp_ready_i     (resp_ready_i),
      .resp_rdata_o     (resp_rdata_o),
      .resp_err_o       (resp_err_o)
   );

endmodule

/* demux/resp_merger.sv */
// ----------------------------------------------------------
// In-order response merger
// ----------------------------------------------------------

`timescale 1ns/100ps

module resp_merger
(
   // Head of the order FIFO
   input  logic                                                    pop_valid_i,
   input  logic [demux_pkg::DEST_WIDTH-1:0]                        pop_dest_i,
   output logic                                                    pop_ready_o,

   // Slave responses
   input  logic [demux_pkg::NUM_SLAVES-1:0]                        slv_resp_valid_i,
   output logic [demux_pkg::NUM_SLAVES-1:0]                        slv_resp_ready_o,
   input  logic [demux_pkg::NUM_SLAVES-1:0][demux_pkg::DATA_WIDTH-1:0] slv_resp_rdata_i,

   // Master response
   output logic                                                    resp_valid_o,
   input  logic                                                    resp_ready_i,
   output logic [demux_pkg::DATA_WIDTH-1:0]                        resp_rdata_o,
   output logic                                                    resp_err_o
);

   logic [demux_pkg::SLAVE_SEL_WIDTH-1:0] head_sel;
   logic                                  head_err;

   // Decode the head id
   assign head_sel = pop_dest_i[demux_pkg::SLAVE_SEL_WIDTH-1:0];
   assign head_err = (pop_dest_i == demux_pkg::DEST_ERR);

   // Steer the head slave to the master
   always_comb
   begin
      slv_resp_ready_o = '0;
      resp_valid_o     = 1'b0;
      resp_rdata_o     = '0;
      resp_err_o       = 1'b0;

      if (pop_valid_i)
      begin
         if (head_err)
         begin
            // Decode error answered locally, data stays zero
            resp_valid_o = 1'b1;
            resp_err_o   = 1'b1;
         end
         else
         begin
            // Only the head slave sees a ready
            resp_valid_o               = slv_resp_valid_i[head_sel];
            resp_rdata_o               = slv_resp_rdata_i[head_sel];
            slv_resp_ready_o[head_sel] = resp_ready_i;
         end
      end
   end

   // Retire the head on a master handshake
   assign pop_ready_o = resp_valid_o & resp_ready_i;

endmodule

/* demux/addr_decoder.sv */
// ----------------------------------------------------------
// Request address decoder stage
// ----------------------------------------------------------

`timescale 1ns/100ps

module addr_decoder
(
   input  logic                                 clk,
   input  logic                                 rst_n,

   // Master request
   input  logic                                 req_valid_i,
   output logic                                 req_ready_o,
   input  logic [demux_pkg::ADDR_WIDTH-1:0]     req_addr_i,
   input  demux_pkg::req_op_e                   req_op_i,
   input  logic [demux_pkg::DATA_WIDTH-1:0]     req_wdata_i,

   // Destination id toward the order FIFO
   output logic                                 push_valid_o,
   output logic [demux_pkg::DEST_WIDTH-1:0]     push_dest_o,
   input  logic                                 push_ready_i,

   // Slave request ports
   output logic [demux_pkg::NUM_SLAVES-1:0]     slv_req_valid_o,
   input  logic [demux_pkg::NUM_SLAVES-1:0]     slv_req_ready_i,
   output logic [demux_pkg::ADDR_WIDTH-1:0]     slv_req_addr_o,
   output demux_pkg::req_op_e                   slv_req_op_o,
   output logic [demux_pkg::DATA_WIDTH-1:0]     slv_req_wdata_o
);

   logic [demux_pkg::SLAVE_SEL_WIDTH-1:0] req_sel;
   logic [demux_pkg::NUM_SLAVES-1:0]      sel_onehot;
   logic                                  is_err;
   logic                                  out_busy;
   logic                                  out_done;
   logic                                  out_free;
   logic                                  accept;

   // Output register
   logic [demux_pkg::NUM_SLAVES-1:0]  out_valid_q;
   logic [demux_pkg::ADDR_WIDTH-1:0]  out_addr_q;
   demux_pkg::req_op_e                out_op_q;
   logic [demux_pkg::DATA_WIDTH-1:0]  out_wdata_q;

   // Address decode
   assign req_sel = req_addr_i[demux_pkg::SLAVE_SEL_LSB +: demux_pkg::SLAVE_SEL_WIDTH];
   assign is_err  = (req_addr_i >= demux_pkg::MAP_TOP);

   always_comb
   begin
      sel_onehot          = '0;
      sel_onehot[req_sel] = 1'b1;
   end

   // Error ids skip the slaves entirely
   assign push_dest_o = is_err ? demux_pkg::DEST_ERR
      : {{(demux_pkg::DEST_WIDTH - demux_pkg::SLAVE_SEL_WIDTH){1'b0}}, req_sel};

   // Register is free when empty or handed off this edge
   assign out_busy = |out_valid_q;
   assign out_done = |(out_valid_q & slv_req_ready_i);
   assign out_free = !out_busy || out_done;

   // Push offered independently of the FIFO grant
   assign push_valid_o = req_valid_i & out_free;
   assign req_ready_o  = out_free & push_ready_i;
   assign accept       = req_valid_i & req_ready_o;

   // One-hot valid toward the addressed slave
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         out_valid_q <= '0;
      end
      else if (accept && !is_err)
      begin
         out_valid_q <= sel_onehot;
      end
      else if (out_done)
      begin
         out_valid_q <= '0;
      end
   end

   // Payload, loaded only for mapped requests
   always_ff @(posedge clk)
   begin
      if (accept && !is_err)
      begin
         out_addr_q  <= req_addr_i;
         out_op_q    <= req_op_i;
         out_wdata_q <= req_wdata_i;
      end
   end

   assign slv_req_valid_o = out_valid_q;
   assign slv_req_addr_o  = out_addr_q;
   assign slv_req_op_o    = out_op_q;
   assign slv_req_wdata_o = out_wdata_q;

endmodule

/* fifo/order_fifo.sv */
// ----------------------------------------------------------
// Order FIFO for destination ids
// ----------------------------------------------------------

`timescale 1ns/100ps

module order_fifo
(
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             clear_i,
   input  logic                             test_mode_i,

   // Push side, fed by the address decoder
   input  logic                             push_valid_i,
   input  logic [demux_pkg::DEST_WIDTH-1:0] push_dest_i,
   output logic                             push_ready_o,

   // Pop side, drained by the response merger
   output logic                             pop_valid_o,
   output logic [demux_pkg::DEST_WIDTH-1:0] pop_dest_o,
   input  logic                             pop_ready_i
);

   demux_pkg::fifo_state_e state_q;
   demux_pkg::fifo_state_e state_d;

   logic [demux_pkg::FIFO_PTR_WIDTH-1:0] push_ptr_q;
   logic [demux_pkg::FIFO_PTR_WIDTH-1:0] push_ptr_d;
   logic [demux_pkg::FIFO_PTR_WIDTH-1:0] push_ptr_inc;
   logic [demux_pkg::FIFO_PTR_WIDTH-1:0] pop_ptr_q;
   logic [demux_pkg::FIFO_PTR_WIDTH-1:0] pop_ptr_d;
   logic [demux_pkg::FIFO_PTR_WIDTH-1:0] pop_ptr_inc;

   logic push_en;
   logic pop_en;
   logic clk_gated;

   // Entry storage
   logic [demux_pkg::DEST_WIDTH-1:0] mem_q [demux_pkg::FIFO_DEPTH];

   // Handshake flags straight from the state
   assign push_ready_o = (state_q != demux_pkg::FIFO_FULL);
   assign pop_valid_o  = (state_q != demux_pkg::FIFO_EMPTY);

   assign push_en = push_valid_i & push_ready_o;
   assign pop_en  = pop_valid_o & pop_ready_i;

   // Wrapping pointer increments
   assign push_ptr_inc = (push_ptr_q == (demux_pkg::FIFO_DEPTH - 1)) ? '0 : push_ptr_q + 1'b1;
   assign pop_ptr_inc  = (pop_ptr_q == (demux_pkg::FIFO_DEPTH - 1)) ? '0 : pop_ptr_q + 1'b1;

   // Next state and pointers
   always_comb
   begin
      state_d    = state_q;
      push_ptr_d = push_ptr_q;
      pop_ptr_d  = pop_ptr_q;

      if (push_en)
      begin
         push_ptr_d = push_ptr_inc;
      end
      if (pop_en)
      begin
         pop_ptr_d = pop_ptr_inc;
      end

      case (state_q)
         demux_pkg::FIFO_EMPTY:
         begin
            if (push_en)
            begin
               state_d = demux_pkg::FIFO_MIDDLE;
            end
         end
         demux_pkg::FIFO_MIDDLE:
         begin
            // Push alone may catch up with the pop pointer
            if (push_en && !pop_en && (push_ptr_inc == pop_ptr_q))
            begin
               state_d = demux_pkg::FIFO_FULL;
            end
            // Pop alone may drain the last entry
            else if (pop_en && !push_en && (pop_ptr_inc == push_ptr_q))
            begin
               state_d = demux_pkg::FIFO_EMPTY;
            end
         end
         demux_pkg::FIFO_FULL:
         begin
            if (pop_en)
            begin
               state_d = demux_pkg::FIFO_MIDDLE;
            end
         end
         default:
         begin
            state_d = demux_pkg::FIFO_EMPTY;
         end
      endcase
   end

   // Control registers, clear wins over any transfer
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q    <= demux_pkg::FIFO_EMPTY;
         push_ptr_q <= '0;
         pop_ptr_q  <= '0;
      end
      else if (clear_i)
      begin
         state_q    <= demux_pkg::FIFO_EMPTY;
         push_ptr_q <= '0;
         pop_ptr_q  <= '0;
      end
      else
      begin
         state_q    <= state_d;
         push_ptr_q <= push_ptr_d;
         pop_ptr_q  <= pop_ptr_d;
      end
   end

   // Storage clock only ticks on a write
   clock_gate i_clock_gate
   (
      .clk       (clk),
      .en_i      (push_en),
      .test_en_i (test_mode_i),
      .clk_o     (clk_gated)
   );

   // Test mode keeps the clock running, so the write still needs push_en
   always_ff @(posedge clk_gated)
   begin
      if (push_en)
      begin
         mem_q[push_ptr_q] <= push_dest_i;
      end
   end

   // Head entry
   assign pop_dest_o = mem_q[pop_ptr_q];

endmodule

/* logic/clock_gate.sv */
// ----------------------------------------------------------
// Latch based clock gate
// ----------------------------------------------------------

`timescale 1ns/100ps

module clock_gate
(
   input  logic clk,
   input  logic en_i,
   input  logic test_en_i,
   output logic clk_o
);

   logic en_latch;

   // Transparent while clk is low
   // so the enable is stable over the high phase
   always_latch
   begin
      if (!clk)
      begin
         en_latch <= en_i | test_en_i;
      end
   end

   // Glitch free gated clock
   assign clk_o = clk & en_latch;

endmodule

/* common/demux_pkg.sv */
// ----------------------------------------------------------
// Request demultiplexer shared definitions
// ----------------------------------------------------------

package demux_pkg;

   // Master and slave bus widths
   localparam int ADDR_WIDTH = 32;
   localparam int DATA_WIDTH = 32;

   // Slave ports, one 4 KiB window each
   localparam int NUM_SLAVES      = 4;
   localparam int SLAVE_SEL_WIDTH = $clog2(NUM_SLAVES);
   localparam int SLAVE_SEL_LSB   = 12;

   // First address past the mapped region
   localparam logic [ADDR_WIDTH-1:0] MAP_TOP = 32'h0000_4000;

   // Destination ids: 0..3 name a slave, 4 is the error sink
   localparam int DEST_WIDTH = 3;
   localparam logic [DEST_WIDTH-1:0] DEST_ERR = 3'd4;

   // Outstanding request limit, sets the order FIFO size
   localparam int FIFO_DEPTH     = 8;
   localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);

   // Request opcode
   typedef enum logic
   {
      OP_READ  = 1'b0,
      OP_WRITE = 1'b1
   } req_op_e;

   // Order FIFO controller
   // MIDDLE means neither empty nor full
   typedef enum logic [1:0]
   {
      FIFO_EMPTY  = 2'd0,
      FIFO_MIDDLE = 2'd1,
      FIFO_FULL   = 2'd2
   } fifo_state_e;

endpackage
